/* tb.f */
hw/scu_pkg.sv
hw/scu_scan_port.sv
hw/scu_csr_file.sv
hw/scu_rst_qlfy_cell.sv
hw/scu_rst_gen.sv
hw/scu_top.sv
tb/tb_scu_assert.sv
tb/tb_scu.sv

/* Makefile */
# Verilator build and run of the SCU testbench

VERILATOR ?= verilator
TOP       ?= tb_scu
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/tb_scu.sv */
// Testbench for the system control unit, table-driven scan operations with reset checks

`timescale 1ns/1ps

module tb_scu;

    import scu_pkg::*;

    localparam int NUM_TESTS      = 38;
    localparam int RESET_CYCLES   = 8;
    // Longer than 2 + SCU_SYNC_STAGES
    localparam int SETTLE_CYCLES  = 8;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 40;

    // One row of stimulus and expected results
    // ext      {rst_n, cpu_rst_n, ndm_rst_n, hart_rst_n}
    // exp_rd   only checked for READ
    // exp_rst  {dm, hdu, core, sys}, 1 means released
    // exp_qlfy {hdu2dm, core, sys}
    typedef struct {
        string                 name;
        scu_op_e               op;
        scu_addr_e             addr;
        logic [SCU_DATA_W-1:0] data;
        logic [3:0]            ext;
        logic [SCU_DATA_W-1:0] exp_rd;
        logic [3:0]            exp_rst;
        logic [2:0]            exp_qlfy;
    } test_vec_t;

    logic clk;
    logic pwrup_rst_n_sync;
    logic ch_sel;
    logic ch_id;
    logic ch_capture;
    logic ch_shift;
    logic ch_update;
    logic ch_tdi;
    logic ch_tdo;
    logic rst_n;
    logic cpu_rst_n;
    logic ndm_rst_n;
    logic hart_rst_n;
    logic sys_rst_n;
    logic core_rst_n;
    logic hdu_rst_n;
    logic dm_rst_n;
    logic sys_qlfy;
    logic core_qlfy;
    logic hdu_qlfy;
    logic sys_sts;
    logic core_sts;

    logic [SCU_DATA_W-1:0] rd;
    logic                  test_ok;
    int                    err_cnt;
    int                    pass_cnt;
    int                    fail_cnt;

    // ----------------------------------------
    // Test table
    // ----------------------------------------

    // Power-up reset leaves every sticky bit set
    test_vec_t tests [NUM_TESTS] = '{
        '{"sticky_pwrup",     SCU_OP_READ,    SCU_ADDR_STICKY,  4'h0, 4'hF, 4'hF, 4'hF, 3'h7},
        '{"sticky_clr_pwrup", SCU_OP_CLRBITS, SCU_ADDR_STICKY,  4'hF, 4'hF, 4'h0, 4'hF, 3'h7},
        '{"sticky_read_0",    SCU_OP_READ,    SCU_ADDR_STICKY,  4'h0, 4'hF, 4'h0, 4'hF, 3'h7},
        // Upper CONTROL bits steer nothing
        '{"ctrl_write",       SCU_OP_WRITE,   SCU_ADDR_CONTROL, 4'hC, 4'hF, 4'h0, 4'hF, 3'h7},
        '{"ctrl_read",        SCU_OP_READ,    SCU_ADDR_CONTROL, 4'h0, 4'hF, 4'hC, 4'hF, 3'h7},
        '{"mode_write",       SCU_OP_WRITE,   SCU_ADDR_MODE,    4'h8, 4'hF, 4'h0, 4'hF, 3'h7},
        '{"mode_set",         SCU_OP_SETBITS, SCU_ADDR_MODE,    4'h5, 4'hF, 4'h0, 4'hF, 3'h7},
        '{"mode_read_set",    SCU_OP_READ,    SCU_ADDR_MODE,    4'h0, 4'hF, 4'hD, 4'hF, 3'h7},
        '{"mode_clr",         SCU_OP_CLRBITS, SCU_ADDR_MODE,    4'hC, 4'hF, 4'h0, 4'hF, 3'h7},
        '{"mode_read_clr",    SCU_OP_READ,    SCU_ADDR_MODE,    4'h0, 4'hF, 4'h1, 4'hF, 3'h7},
        '{"ctrl_clear",       SCU_OP_WRITE,   SCU_ADDR_CONTROL, 4'h0, 4'hF, 4'h0, 4'hF, 3'h7},
        // System reset with DM behavior set takes all four down
        '{"sys_rst_on",       SCU_OP_SETBITS, SCU_ADDR_CONTROL, 4'h1, 4'hF, 4'h0, 4'h0, 3'h0},
        '{"status_read",      SCU_OP_READ,    SCU_ADDR_STATUS,  4'h0, 4'hF, 4'hF, 4'h0, 3'h0},
        '{"sys_rst_off",      SCU_OP_CLRBITS, SCU_ADDR_CONTROL, 4'h1, 4'hF, 4'h0, 4'hF, 3'h7},
        '{"sticky_read_sys",  SCU_OP_READ,    SCU_ADDR_STICKY,  4'h0, 4'hF, 4'hF, 4'hF, 3'h7},
        '{"sticky_clr_sys",   SCU_OP_CLRBITS, SCU_ADDR_STICKY,  4'h1, 4'hF, 4'h0, 4'hF, 3'h7},
        // WRITE must not touch STICKY_STATUS
        '{"sticky_write",     SCU_OP_WRITE,   SCU_ADDR_STICKY,  4'h0, 4'hF, 4'h0, 4'hF, 3'h7},
        '{"sticky_read_wr",   SCU_OP_READ,    SCU_ADDR_STICKY,  4'h0, 4'hF, 4'hE, 4'hF, 3'h7},
        '{"sticky_clr_rest",  SCU_OP_CLRBITS, SCU_ADDR_STICKY,  4'hE, 4'hF, 4'h0, 4'hF, 3'h7},
        '{"sticky_read_clr",  SCU_OP_READ,    SCU_ADDR_STICKY,  4'h0, 4'hF, 4'h0, 4'hF, 3'h7},
        '{"mode_dm_off",      SCU_OP_WRITE,   SCU_ADDR_MODE,    4'h0, 4'hF, 4'h0, 4'hF, 3'h7},
        '{"sys_rst_no_dm",    SCU_OP_SETBITS, SCU_ADDR_CONTROL, 4'h1, 4'hF, 4'h0, 4'h8, 3'h0},
        '{"sys_rst_no_dm_off",SCU_OP_CLRBITS, SCU_ADDR_CONTROL, 4'h1, 4'hF, 4'h0, 4'hF, 3'h7},
        // Core reset, then keep HDU out of it
        '{"core_rst_on",      SCU_OP_WRITE,   SCU_ADDR_CONTROL, 4'h2, 4'hF, 4'h0, 4'h9, 3'h1},
        '{"hdu_keep",         SCU_OP_WRITE,   SCU_ADDR_MODE,    4'h2, 4'hF, 4'h0, 4'hD, 3'h5},
        // Only the core bit is up while HDU is kept out
        '{"status_core",      SCU_OP_READ,    SCU_ADDR_STATUS,  4'h0, 4'hF, 4'h2, 4'hD, 3'h5},
        '{"dm_bhv_core",      SCU_OP_SETBITS, SCU_ADDR_MODE,    4'h1, 4'hF, 4'h0, 4'hD, 3'h5},
        '{"core_rst_off",     SCU_OP_WRITE,   SCU_ADDR_CONTROL, 4'h0, 4'hF, 4'h0, 4'hF, 3'h7},
        '{"mode_reset",       SCU_OP_WRITE,   SCU_ADDR_MODE,    4'h0, 4'hF, 4'h0, 4'hF, 3'h7},
        // External requests
        '{"ndm_low",          SCU_OP_READ,    SCU_ADDR_CONTROL, 4'h0, 4'hD, 4'h0, 4'h8, 3'h0},
        '{"ndm_high",         SCU_OP_READ,    SCU_ADDR_CONTROL, 4'h0, 4'hF, 4'h0, 4'hF, 3'h7},
        '{"hart_low",         SCU_OP_READ,    SCU_ADDR_MODE,    4'h0, 4'hE, 4'h0, 4'h9, 3'h1},
        '{"hart_high",        SCU_OP_READ,    SCU_ADDR_STATUS,  4'h0, 4'hF, 4'h0, 4'hF, 3'h7},
        '{"rst_low",          SCU_OP_READ,    SCU_ADDR_CONTROL, 4'h0, 4'h7, 4'h0, 4'h8, 3'h0},
        '{"rst_high",         SCU_OP_READ,    SCU_ADDR_STATUS,  4'h0, 4'hF, 4'h0, 4'hF, 3'h7},
        '{"cpu_low",          SCU_OP_READ,    SCU_ADDR_MODE,    4'h0, 4'hB, 4'h0, 4'h9, 3'h1},
        '{"cpu_high",         SCU_OP_READ,    SCU_ADDR_CONTROL, 4'h0, 4'hF, 4'h0, 4'hF, 3'h7},
        // Sys, core and hdu events since the last clear, no DM reset
        '{"sticky_read_end",  SCU_OP_READ,    SCU_ADDR_STICKY,  4'h0, 4'hF, 4'hB, 4'hF, 3'h7}
    };

    scu_top u_dut (
        .clk               (clk),
        .pwrup_rst_n_sync  (pwrup_rst_n_sync),
        .ch_sel_i          (ch_sel),
        .ch_id_i           (ch_id),
        .ch_capture_i      (ch_capture),
        .ch_shift_i        (ch_shift),
        .ch_update_i       (ch_update),
        .ch_tdi_i          (ch_tdi),
        .ch_tdo_o          (ch_tdo),
        .rst_n_i           (rst_n),
        .cpu_rst_n_i       (cpu_rst_n),
        .ndm_rst_n_i       (ndm_rst_n),
        .hart_rst_n_i      (hart_rst_n),
        .sys_rst_n_o       (sys_rst_n),
        .core_rst_n_o      (core_rst_n),
        .hdu_rst_n_o       (hdu_rst_n),
        .dm_rst_n_o        (dm_rst_n),
        .sys_rdc_qlfy_o    (sys_qlfy),
        .core_rdc_qlfy_o   (core_qlfy),
        .hdu2dm_rdc_qlfy_o (hdu_qlfy),
        .sys_rst_status_o  (sys_sts),
        .core_rst_status_o (core_sts)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ----------------------------------------
    // Tasks
    // ----------------------------------------

    // Starts and ends on a falling edge
    // Shift in, update, and for READ capture and shift the result out
    task automatic scan_op(input scu_op_e op, input scu_addr_e addr,
                           input logic [SCU_DATA_W-1:0] data,
                           output logic [SCU_DATA_W-1:0] rdata);
        scu_dr_t dr;
        scu_dr_t res;
        dr.data    = data;
        dr.addr    = addr;
        dr.op      = op;
        res        = '0;
        ch_sel     = 1'b1;
        ch_shift   = 1'b1;
        // LSB first
        for (int i = 0; i < SCU_DR_W; i++) begin
            ch_tdi = dr[i];
            @(negedge clk);
        end
        ch_shift  = 1'b0;
        ch_tdi    = 1'b0;
        ch_update = 1'b1;
        @(negedge clk);
        ch_update = 1'b0;
        if (op == SCU_OP_READ) begin
            ch_capture = 1'b1;
            @(negedge clk);
            ch_capture = 1'b0;
            ch_shift   = 1'b1;
            // tdo already holds the bit for this cycle
            for (int i = 0; i < SCU_DR_W; i++) begin
                res[i] = ch_tdo;
                @(negedge clk);
            end
            ch_shift = 1'b0;
        end
        ch_sel = 1'b0;
        rdata  = res.data;
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [3:0] expected, input logic [3:0] actual);
        if (actual !== expected) begin
            $display("** Error %s %s: expected %h, actual %h", name, what, expected, actual);
            err_cnt++;
            test_ok = 1'b0;
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        ch_sel           = 1'b0;
        ch_id            = 1'b0;
        ch_capture       = 1'b0;
        ch_shift         = 1'b0;
        ch_update        = 1'b0;
        ch_tdi           = 1'b0;
        rst_n            = 1'b1;
        cpu_rst_n        = 1'b1;
        ndm_rst_n        = 1'b1;
        hart_rst_n       = 1'b1;
        err_cnt          = 0;
        pass_cnt         = 0;
        fail_cnt         = 0;
        pwrup_rst_n_sync = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        pwrup_rst_n_sync = 1'b1;

        for (int t = 0; t < NUM_TESTS; t++) begin
            test_ok = 1'b1;
            {rst_n, cpu_rst_n, ndm_rst_n, hart_rst_n} = tests[t].ext;
            scan_op(tests[t].op, tests[t].addr, tests[t].data, rd);
            repeat (SETTLE_CYCLES) @(negedge clk);
            if (tests[t].op == SCU_OP_READ) begin
                check_value(tests[t].name, "read data", tests[t].exp_rd, rd);
            end
            check_value(tests[t].name, "resets", tests[t].exp_rst,
                        {dm_rst_n, hdu_rst_n, core_rst_n, sys_rst_n});
            check_value(tests[t].name, "qualifiers", {1'b0, tests[t].exp_qlfy},
                        {1'b0, hdu_qlfy, core_qlfy, sys_qlfy});
            // Status outputs mirror asserted resets once synchronized
            check_value(tests[t].name, "status",
                        {2'b00, ~tests[t].exp_rst[1], ~tests[t].exp_rst[0]},
                        {2'b00, core_sts, sys_sts});
            if (test_ok) begin
                pass_cnt++;
                $display("%-18s ok", tests[t].name);
            end else begin
                fail_cnt++;
                $display("%-18s FAILED", tests[t].name);
            end
        end

        $display("Tests run %0d, ok %0d, failed %0d, check errors %0d",
                 NUM_TESTS, pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, the test sequence did not finish", TIMEOUT_CYCLES);
        $display("Verification failed");
        $finish;
    end

endmodule : tb_scu

/* tb/tb_scu_assert.sv */
// Qualifier ordering assertions for every qualified reset channel

`timescale 1ns/1ps

module tb_scu_assert (
    input logic clk,
    input logic pwrup_rst_n_sync,
    input logic rst_n_i,
    input logic qlfy_i
);

    // ----------------------------------------
    // Qualifier sequencing
    // ----------------------------------------

    // Qualifier drops one cycle before the reset
    a_qlfy_before_rst_fall: assert property (
        @(posedge clk) disable iff (!pwrup_rst_n_sync)
        $fell(rst_n_i) |-> (!$past(qlfy_i) && $past(qlfy_i, 2))
    ) else $error("reset fell without a qualifier fall one cycle earlier");

    // Qualifier rises one cycle after the reset releases
    a_qlfy_after_rst_rise: assert property (
        @(posedge clk) disable iff (!pwrup_rst_n_sync)
        $rose(rst_n_i) |=> $rose(qlfy_i)
    ) else $error("qualifier did not rise one cycle after reset release");

endmodule : tb_scu_assert

bind scu_rst_qlfy_cell tb_scu_assert u_assert (
    .clk              (clk),
    .pwrup_rst_n_sync (pwrup_rst_n_sync),
    .rst_n_i          (rst_n_o),
    .qlfy_i           (qlfy_o)
);

/* hw/scu_top.sv */
// System control unit top level chaining scan port, register file and reset generation

`timescale 1ns/1ps

module scu_top (
    input  logic clk,
    input  logic pwrup_rst_n_sync,
    // Synchronized TAP chain
    input  logic ch_sel_i,
    input  logic ch_id_i,
    input  logic ch_capture_i,
    input  logic ch_shift_i,
    input  logic ch_update_i,
    input  logic ch_tdi_i,
    output logic ch_tdo_o,
    // External reset requests
    input  logic rst_n_i,
    input  logic cpu_rst_n_i,
    input  logic ndm_rst_n_i,
    input  logic hart_rst_n_i,
    // Generated resets and qualifiers
    output logic sys_rst_n_o,
    output logic core_rst_n_o,
    output logic hdu_rst_n_o,
    output logic dm_rst_n_o,
    output logic sys_rdc_qlfy_o,
    output logic core_rdc_qlfy_o,
    output logic hdu2dm_rdc_qlfy_o,
    output logic sys_rst_status_o,
    output logic core_rst_status_o
);

    import scu_pkg::*;

    scu_csr_req_t          csr_req;
    logic [SCU_DATA_W-1:0] csr_wdata;
    scu_ctrl_t             ctrl;
    scu_status_t           status;

    scu_scan_port u_scan (
        .clk              (clk),
        .pwrup_rst_n_sync (pwrup_rst_n_sync),
        .ch_sel_i         (ch_sel_i),
        .ch_id_i          (ch_id_i),
        .ch_capture_i     (ch_capture_i),
        .ch_shift_i       (ch_shift_i),
        .ch_update_i      (ch_update_i),
        .ch_tdi_i         (ch_tdi_i),
        .ch_tdo_o         (ch_tdo_o),
        .csr_wdata_i      (csr_wdata),
        .csr_req_o        (csr_req)
    );

    scu_csr_file u_csr (
        .clk              (clk),
        .pwrup_rst_n_sync (pwrup_rst_n_sync),
        .csr_req_i        (csr_req),
        .status_i         (status),
        .csr_wdata_o      (csr_wdata),
        .ctrl_o           (ctrl)
    );

    scu_rst_gen u_rst (
        .clk               (clk),
        .pwrup_rst_n_sync  (pwrup_rst_n_sync),
        .ctrl_i            (ctrl),
        .rst_n_i           (rst_n_i),
        .cpu_rst_n_i       (cpu_rst_n_i),
        .ndm_rst_n_i       (ndm_rst_n_i),
        .hart_rst_n_i      (hart_rst_n_i),
        .sys_rst_n_o       (sys_rst_n_o),
        .core_rst_n_o      (core_rst_n_o),
        .hdu_rst_n_o       (hdu_rst_n_o),
        .dm_rst_n_o        (dm_rst_n_o),
        .sys_rdc_qlfy_o    (sys_rdc_qlfy_o),
        .core_rdc_qlfy_o   (core_rdc_qlfy_o),
        .hdu2dm_rdc_qlfy_o (hdu2dm_rdc_qlfy_o),
        .sys_rst_status_o  (sys_rst_status_o),
        .core_rst_status_o (core_rst_status_o),
        .status_o          (status)
    );

endmodule : scu_top

/* hw/scu_rst_gen.sv */
// SCU reset generation for system, core, HDU and DM resets with RDC qualifiers

`timescale 1ns/1ps

module scu_rst_gen (
    input  logic                 clk,
    input  logic                 pwrup_rst_n_sync,
    input  scu_pkg::scu_ctrl_t   ctrl_i,
    // External reset requests
    input  logic                 rst_n_i,
    input  logic                 cpu_rst_n_i,
    input  logic                 ndm_rst_n_i,
    input  logic                 hart_rst_n_i,
    // Generated resets
    output logic                 sys_rst_n_o,
    output logic                 core_rst_n_o,
    output logic                 hdu_rst_n_o,
    output logic                 dm_rst_n_o,
    // RDC qualifiers
    output logic                 sys_rdc_qlfy_o,
    output logic                 core_rdc_qlfy_o,
    output logic                 hdu2dm_rdc_qlfy_o,
    // Status
    output logic                 sys_rst_status_o,
    output logic                 core_rst_status_o,
    output scu_pkg::scu_status_t status_o
);

    import scu_pkg::*;

    logic sys_req_n;
    logic core_req_n;
    logic hdu_req_n;
    logic hdu_status;
    logic dm_rst_n_q;

    // ----------------------------------------
    // Request combination
    // ----------------------------------------

    assign sys_req_n  = ~ctrl_i.sys_reset & ndm_rst_n_i & rst_n_i;
    // Core follows system plus its own sources
    assign core_req_n = sys_req_n & hart_rst_n_i & ~ctrl_i.core_reset & cpu_rst_n_i;
    // HDU may be kept out of core reset
    assign hdu_req_n  = core_req_n | ctrl_i.hdu_rst_bhv;

    // ----------------------------------------
    // Qualified channels
    // ----------------------------------------

    scu_rst_qlfy_cell u_sys (
        .clk              (clk),
        .pwrup_rst_n_sync (pwrup_rst_n_sync),
        .rst_n_req_i      (sys_req_n),
        .rst_n_o          (sys_rst_n_o),
        .qlfy_o           (sys_rdc_qlfy_o),
        .status_o         (sys_rst_status_o)
    );

    scu_rst_qlfy_cell u_core (
        .clk              (clk),
        .pwrup_rst_n_sync (pwrup_rst_n_sync),
        .rst_n_req_i      (core_req_n),
        .rst_n_o          (core_rst_n_o),
        .qlfy_o           (core_rdc_qlfy_o),
        .status_o         (core_rst_status_o)
    );

    scu_rst_qlfy_cell u_hdu (
        .clk              (clk),
        .pwrup_rst_n_sync (pwrup_rst_n_sync),
        .rst_n_req_i      (hdu_req_n),
        .rst_n_o          (hdu_rst_n_o),
        .qlfy_o           (hdu2dm_rdc_qlfy_o),
        .status_o         (hdu_status)
    );

    // DM reset only on system reset with DM behavior set
    always_ff @(posedge clk or negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            dm_rst_n_q <= 1'b0;
        end else begin
            dm_rst_n_q <= ~(ctrl_i.dm_rst_bhv & ctrl_i.sys_reset);
        end
    end

    assign dm_rst_n_o = dm_rst_n_q;

    // DM status is already in this domain
    assign status_o.sys_reset  = sys_rst_status_o;
    assign status_o.core_reset = core_rst_status_o;
    assign status_o.dm_reset   = ~dm_rst_n_q;
    assign status_o.hdu_reset  = hdu_status;

endmodule : scu_rst_gen

/* hw/scu_rst_qlfy_cell.sv */
// Qualified reset channel sequencing the RDC qualifier around its reset, with status sync

`timescale 1ns/1ps

module scu_rst_qlfy_cell (
    input  logic clk,
    input  logic pwrup_rst_n_sync,
    input  logic rst_n_req_i,
    output logic rst_n_o,
    output logic qlfy_o,
    output logic status_o
);

    import scu_pkg::*;

    scu_qlfy_state_e             state_q;
    scu_qlfy_state_e             state_d;
    logic [SCU_SYNC_STAGES-1:0]  sts_sync_q;

    // Qualifier drops first on entry, rises last on exit
    always_comb begin
        state_d = state_q;
        case (state_q)
            RUN:     state_d = rst_n_req_i ? RUN : QLFY;
            QLFY:    state_d = rst_n_req_i ? RUN : RESET;
            RESET:   state_d = rst_n_req_i ? QLFY : RESET;
            default: state_d = RESET;
        endcase
    end

    // Power-up leaves the channel in reset
    always_ff @(posedge clk or negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            state_q <= RESET;
        end else begin
            state_q <= state_d;
        end
    end

    // Outputs straight from state flops
    assign rst_n_o = state_q[0];
    assign qlfy_o  = state_q[1];

    // Reset status back into the power-up domain
    always_ff @(posedge clk or negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            sts_sync_q <= '0;
        end else begin
            sts_sync_q <= {sts_sync_q[SCU_SYNC_STAGES-2:0], ~rst_n_o};
        end
    end

    assign status_o = sts_sync_q[SCU_SYNC_STAGES-1];

endmodule : scu_rst_qlfy_cell

/* hw/scu_csr_file.sv */
// SCU register file holding CONTROL, MODE and STICKY_STATUS with operation decode

`timescale 1ns/1ps

module scu_csr_file (
    input  logic                           clk,
    input  logic                           pwrup_rst_n_sync,
    input  scu_pkg::scu_csr_req_t          csr_req_i,
    input  scu_pkg::scu_status_t           status_i,
    output logic [scu_pkg::SCU_DATA_W-1:0] csr_wdata_o,
    output scu_pkg::scu_ctrl_t             ctrl_o
);

    import scu_pkg::*;

    logic [SCU_DATA_W-1:0] control_q;
    logic [SCU_DATA_W-1:0] mode_q;
    logic [SCU_DATA_W-1:0] sticky_q;
    logic [SCU_DATA_W-1:0] sticky_d;
    logic [SCU_DATA_W-1:0] rdata;
    scu_status_t           status_dly_q;
    scu_status_t           status_rise;
    logic                  modify_req;
    logic                  control_wr;
    logic                  mode_wr;
    logic                  sticky_wr;

    // ----------------------------------------
    // Request decode
    // ----------------------------------------

    // Every op but READ modifies the target
    assign modify_req = csr_req_i.valid && (csr_req_i.op != SCU_OP_READ);
    assign control_wr = modify_req && (csr_req_i.addr == SCU_ADDR_CONTROL);
    assign mode_wr    = modify_req && (csr_req_i.addr == SCU_ADDR_MODE);
    // Sticky bits are only cleared by the debugger
    assign sticky_wr  = csr_req_i.valid && (csr_req_i.op == SCU_OP_CLRBITS)
                     && (csr_req_i.addr == SCU_ADDR_STICKY);

    // Read multiplexer, STATUS is live
    always_comb begin
        rdata = '0;
        case (csr_req_i.addr)
            SCU_ADDR_CONTROL: rdata = control_q;
            SCU_ADDR_MODE:    rdata = mode_q;
            SCU_ADDR_STATUS:  rdata = status_i;
            SCU_ADDR_STICKY:  rdata = sticky_q;
            default:          rdata = '0;
        endcase
    end

    // Operation result, also returned to the shadow register
    always_comb begin
        csr_wdata_o = rdata;
        case (csr_req_i.op)
            SCU_OP_WRITE:   csr_wdata_o = csr_req_i.data;
            SCU_OP_READ:    csr_wdata_o = rdata;
            SCU_OP_SETBITS: csr_wdata_o = rdata | csr_req_i.data;
            SCU_OP_CLRBITS: csr_wdata_o = rdata & ~csr_req_i.data;
            default:        csr_wdata_o = rdata;
        endcase
    end

    // ----------------------------------------
    // Registers
    // ----------------------------------------

    always_ff @(posedge clk or negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            control_q <= '0;
            mode_q    <= '0;
        end else begin
            if (control_wr) begin
                control_q <= csr_wdata_o;
            end
            if (mode_wr) begin
                mode_q <= csr_wdata_o;
            end
        end
    end

    // Rising edges of the reset status
    assign status_rise = status_i & ~status_dly_q;

    // A new reset event beats a clear in the same cycle
    assign sticky_d = sticky_wr ? csr_wdata_o : sticky_q;

    always_ff @(posedge clk or negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            status_dly_q <= '0;
            sticky_q     <= '0;
        end else begin
            status_dly_q <= status_i;
            sticky_q     <= sticky_d | status_rise;
        end
    end

    // Only the low CONTROL and MODE bits steer the resets
    assign ctrl_o.sys_reset   = control_q[0];
    assign ctrl_o.core_reset  = control_q[1];
    assign ctrl_o.dm_rst_bhv  = mode_q[0];
    assign ctrl_o.hdu_rst_bhv = mode_q[1];

endmodule : scu_csr_file

/* hw/scu_scan_port.sv */
// SCU scan port with chain select decode, scan shift register and result shadow register

`timescale 1ns/1ps

module scu_scan_port (
    input  logic                         clk,
    input  logic                         pwrup_rst_n_sync,
    // Synchronized TAP chain controls
    input  logic                         ch_sel_i,
    input  logic                         ch_id_i,
    input  logic                         ch_capture_i,
    input  logic                         ch_shift_i,
    input  logic                         ch_update_i,
    input  logic                         ch_tdi_i,
    output logic                         ch_tdo_o,
    // Register file side
    input  logic [scu_pkg::SCU_DATA_W-1:0] csr_wdata_i,
    output scu_pkg::scu_csr_req_t        csr_req_o
);

    import scu_pkg::*;

    logic    ch_hit;
    logic    dr_capture;
    logic    dr_shift;
    logic    dr_update;
    scu_dr_t shift_q;
    scu_dr_t shadow_q;

    // ----------------------------------------
    // Chain decode
    // ----------------------------------------

    // SCU owns chain 0
    assign ch_hit     = ch_sel_i & ~ch_id_i;
    assign dr_capture = ch_hit & ch_capture_i;
    assign dr_shift   = ch_hit & ch_shift_i;
    assign dr_update  = ch_hit & ch_update_i;

    // ----------------------------------------
    // Shift register
    // ----------------------------------------

    always_ff @(posedge clk or negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            shift_q <= '0;
        end else if (dr_capture) begin
            // Last result goes out on the next shifts
            shift_q <= shadow_q;
        end else if (dr_shift) begin
            // LSB first, tdi enters at the top
            shift_q <= {ch_tdi_i, shift_q[SCU_DR_W-1:1]};
        end
    end

    assign ch_tdo_o = shift_q[0];

    // ----------------------------------------
    // Shadow register
    // ----------------------------------------

    // Keeps op and addr of the request plus its result
    always_ff @(posedge clk or negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            shadow_q <= '0;
        end else if (dr_update) begin
            shadow_q.op   <= shift_q.op;
            shadow_q.addr <= shift_q.addr;
            shadow_q.data <= csr_wdata_i;
        end
    end

    // One-cycle request on an addressed update
    assign csr_req_o.valid = dr_update;
    assign csr_req_o.op    = shift_q.op;
    assign csr_req_o.addr  = shift_q.addr;
    assign csr_req_o.data  = shift_q.data;

endmodule : scu_scan_port

/* hw/scu_pkg.sv */
// System control unit package with widths, scan and CSR encodings, shared structs

package scu_pkg;

    // ----------------------------------------
    // Widths and depths
    // ----------------------------------------

    // Width of every SCU register
    localparam int unsigned SCU_DATA_W      = 4;
    // Scan data register holds op, addr and data
    localparam int unsigned SCU_DR_W        = 8;
    // Status synchronizer depth
    localparam int unsigned SCU_SYNC_STAGES = 2;

    // ----------------------------------------
    // Encodings
    // ----------------------------------------

    // Register operations carried in the scan word
    typedef enum logic [1:0] {
        SCU_OP_WRITE   = 2'd0,
        SCU_OP_READ    = 2'd1,
        SCU_OP_SETBITS = 2'd2,
        SCU_OP_CLRBITS = 2'd3
    } scu_op_e;

    // Register map
    typedef enum logic [1:0] {
        SCU_ADDR_CONTROL = 2'd0,
        SCU_ADDR_MODE    = 2'd1,
        SCU_ADDR_STATUS  = 2'd2,
        SCU_ADDR_STICKY  = 2'd3
    } scu_addr_e;

    // Qualified reset channel states
    // Bit 0 is the reset output, bit 1 the qualifier output
    typedef enum logic [1:0] {
        RESET = 2'b00,
        QLFY  = 2'b01,
        RUN   = 2'b11
    } scu_qlfy_state_e;

    // ----------------------------------------
    // Structures
    // ----------------------------------------

    // Scan word, op sits in the low bits and leaves tdo first
    typedef struct packed {
        logic [SCU_DATA_W-1:0] data;
        scu_addr_e             addr;
        scu_op_e               op;
    } scu_dr_t;

    // Register update request from the scan port
    typedef struct packed {
        logic                  valid;
        scu_op_e               op;
        scu_addr_e             addr;
        logic [SCU_DATA_W-1:0] data;
    } scu_csr_req_t;

    // Reset controls, MODE bits on top and CONTROL bits below
    typedef struct packed {
        logic hdu_rst_bhv;
        logic dm_rst_bhv;
        logic core_reset;
        logic sys_reset;
    } scu_ctrl_t;

    // Reset status, shared by STATUS and STICKY_STATUS
    typedef struct packed {
        logic hdu_reset;
        logic dm_reset;
        logic core_reset;
        logic sys_reset;
    } scu_status_t;

endpackage : scu_pkg
